// ==== common/lanzones_params.svh ====
`ifndef LANZONES_PARAMS_SVH
`define LANZONES_PARAMS_SVH

// datapath sizes
`define XLEN       32
`define REG_COUNT  32
`define REG_AW     5

// major opcodes
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011
`define OPC_LUI    7'b0110111
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_HALT   7'h7F

// funct3 of the ALU group
`define F3_ADD     3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SR      3'b101   // SRL and SRA share it
`define F3_OR      3'b110
`define F3_AND     3'b111

// only word access on the bus
`define F3_WORD    3'b010

// funct7
`define F7_BASE    7'b0000000
`define F7_ALT     7'b0100000   // SUB, SRA

`endif

// ==== common/lanzones_pkg.sv ====
`include "lanzones_params.svh"

package lanzones_pkg;

   // one data word or word address
   typedef logic [`XLEN-1:0] word_t;

   typedef logic [`REG_AW-1:0] regIdx_t;

   // PASS_B forwards operand B for LUI
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      ALU_PASS_B
   } aluOp_e;

endpackage

// ==== common/decodeIf.sv ====
`timescale 1ns/1ps

interface decodeIf import lanzones_pkg::*; ();

   logic    opValid;    // high in the decode cycle only
   aluOp_e  aluOp;
   regIdx_t rs1;
   regIdx_t rs2;        // store data source for SW
   regIdx_t rd;
   word_t   imm;        // already sign extended
   logic    useImm;
   logic    isLoad;
   logic    isStore;
   logic    writesRd;
   logic    isHalt;
   logic    invalid;

   modport dec (
      output opValid, aluOp, rs1, rs2, rd, imm, useImm,
      output isLoad, isStore, writesRd, isHalt, invalid
   );

   modport user (
      input opValid, aluOp, rs1, rs2, rd, imm, useImm,
      input isLoad, isStore, writesRd, isHalt, invalid
   );

endinterface

// ==== core/instDecoder.sv ====
`timescale 1ns/1ps
`include "lanzones_params.svh"

module instDecoder import lanzones_pkg::*; (
   input  logic  clk,
   input  logic  rstn,
   input  logic  fetchDone,
   input  word_t RData,
   decodeIf.dec  dec
);

   word_t       instReg;
   logic        instVld;
   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic        isRegOp;
   logic        fnAlt;
   logic        fnBase;
   aluOp_e      fnOp;
   logic        fnBad;
   word_t       immI;
   word_t       immS;

   always_ff @(posedge clk) begin
      if (fetchDone) begin
         instReg <= RData;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         instVld <= 1'b0;
      end
      else begin
         instVld <= fetchDone;
      end
   end

   assign opcode  = instReg[6:0];
   assign funct3  = instReg[14:12];
   assign funct7  = instReg[31:25];
   assign isRegOp = (opcode == `OPC_OP);
   assign fnAlt   = (funct7 == `F7_ALT);
   assign fnBase  = (funct7 == `F7_BASE);
   assign immI    = {{(`XLEN-12){instReg[31]}}, instReg[31:20]};
   assign immS    = {{(`XLEN-12){instReg[31]}}, instReg[31:25], instReg[11:7]};

   assign dec.opValid = instVld;
   assign dec.rs1     = instReg[19:15];
   assign dec.rs2     = instReg[24:20];
   assign dec.rd      = instReg[11:7];

   // funct3/funct7 to ALU op for OP and OP-IMM
   always_comb begin
      fnBad = 1'b0;
      case (funct3)
         `F3_ADD: begin
            fnOp  = (isRegOp && fnAlt) ? ALU_SUB : ALU_ADD;
            fnBad = isRegOp && !fnAlt && !fnBase;
         end
         `F3_SLL: begin
            fnOp  = ALU_SLL;
            fnBad = !fnBase;   // also for SLLI
         end
         `F3_SR: begin
            fnOp  = fnAlt ? ALU_SRA : ALU_SRL;
            fnBad = !fnAlt && !fnBase;
         end
         `F3_SLT:  fnOp = ALU_SLT;
         `F3_SLTU: fnOp = ALU_SLTU;
         `F3_XOR:  fnOp = ALU_XOR;
         `F3_OR:   fnOp = ALU_OR;
         default:  fnOp = ALU_AND;
      endcase
      if (isRegOp && !fnBase && funct3 != `F3_ADD && funct3 != `F3_SR) begin
         fnBad = 1'b1;
      end
   end

   always_comb begin
      dec.aluOp    = ALU_ADD;
      dec.imm      = immI;
      dec.useImm   = 1'b0;
      dec.isLoad   = 1'b0;
      dec.isStore  = 1'b0;
      dec.writesRd = 1'b0;
      dec.isHalt   = 1'b0;
      dec.invalid  = 1'b0;
      case (opcode)
         `OPC_OP_IMM: begin
            dec.aluOp    = fnOp;
            dec.useImm   = 1'b1;
            dec.writesRd = 1'b1;
            dec.invalid  = fnBad;
         end
         `OPC_OP: begin
            dec.aluOp    = fnOp;
            dec.writesRd = 1'b1;
            dec.invalid  = fnBad;
         end
         `OPC_LUI: begin
            dec.aluOp    = ALU_PASS_B;
            dec.imm      = {instReg[31:12], 12'b0};
            dec.useImm   = 1'b1;
            dec.writesRd = 1'b1;
         end
         `OPC_LOAD: begin
            dec.useImm   = 1'b1;
            dec.isLoad   = 1'b1;
            dec.writesRd = 1'b1;   // written when the bus answers
            dec.invalid  = (funct3 != `F3_WORD);
         end
         `OPC_STORE: begin
            dec.imm     = immS;
            dec.useImm  = 1'b1;
            dec.isStore = 1'b1;
            dec.invalid = (funct3 != `F3_WORD);
         end
         `OPC_HALT: dec.isHalt = 1'b1;
         default:   dec.invalid = 1'b1;
      endcase
   end

endmodule

// ==== core/execUnit.sv ====
`timescale 1ns/1ps
`include "lanzones_params.svh"

module execUnit import lanzones_pkg::*; (
   decodeIf.user op,
   input  word_t rs1Data,
   input  word_t rs2Data,
   output word_t aluResult,
   output word_t storeData
);

   localparam int SHW = $clog2(`XLEN);

   word_t            opA;
   word_t            opB;
   aluOp_e           aluSel;
   logic [SHW-1:0]   shamt;

   assign opA   = rs1Data;
   assign opB   = op.useImm ? op.imm : rs2Data;
   assign shamt = opB[SHW-1:0];

   // address generation always adds
   assign aluSel = (op.isLoad || op.isStore) ? ALU_ADD : op.aluOp;

   always_comb begin
      case (aluSel)
         ALU_SUB: begin
            aluResult = opA - opB;
         end
         ALU_SLL: begin
            aluResult = opA << shamt;
         end
         ALU_SLT: begin
            aluResult = word_t'($signed(opA) < $signed(opB));
         end
         ALU_SLTU: begin
            aluResult = word_t'(opA < opB);
         end
         ALU_XOR: begin
            aluResult = opA ^ opB;
         end
         ALU_SRL: begin
            aluResult = opA >> shamt;
         end
         ALU_SRA: begin
            aluResult = $signed(opA) >>> shamt;
         end
         ALU_OR: begin
            aluResult = opA | opB;
         end
         ALU_AND: begin
            aluResult = opA & opB;
         end
         ALU_PASS_B: begin
            aluResult = opB;   // LUI
         end
         default: begin
            aluResult = opA + opB;
         end
      endcase
   end

   assign storeData = rs2Data;

endmodule

// ==== core/regFile.sv ====
`timescale 1ns/1ps
`include "lanzones_params.svh"

module regFile import lanzones_pkg::*; (
   input  logic    clk,
   input  logic    rstn,
   input  regIdx_t rs1,
   input  regIdx_t rs2,
   output word_t   rs1Data,
   output word_t   rs2Data,
   input  logic    wEn,
   input  regIdx_t wAddr,
   input  word_t   wData
);

   // x0 has no storage
   word_t regs [1:`REG_COUNT-1];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 1; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end
      else begin
         if (wEn && wAddr != '0) begin
            regs[wAddr] <= wData;
         end
      end
   end

   assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== core/coreSequencer.sv ====
`timescale 1ns/1ps
`include "lanzones_params.svh"

module coreSequencer import lanzones_pkg::*; (
   input  logic    clk,
   input  logic    rstn,
   input  logic    LEn,
   input  logic    RVld,
   input  word_t   RData,
   decodeIf.user   op,
   input  word_t   aluResult,
   input  word_t   storeData,
   output logic    RRdy,
   output word_t   RAddr,
   output logic    RWEn,
   output word_t   RWData,
   output logic    Halt,
   output logic    fetchDone,
   output logic    wEn,
   output regIdx_t wAddr,
   output word_t   wData
);

   typedef enum logic [1:0] {
      HALTED,
      FETCH,
      DECODE,
      MEM
   } state_e;

   state_e  state;
   word_t   pc;          // word address
   logic    memWr;       // MEM access is a store
   word_t   memAddr;
   word_t   memData;
   regIdx_t ldRd;

   logic    decodeNow;
   logic    stopNow;
   logic    needMem;
   logic    memDone;

   assign decodeNow = (state == DECODE) && op.opValid;
   assign stopNow   = op.isHalt || op.invalid;
   assign needMem   = op.isLoad || op.isStore;
   assign memDone   = (state == MEM) && RVld;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= HALTED;
         pc    <= '0;
         memWr <= 1'b0;
      end
      else begin
         case (state)
            HALTED: begin
               if (LEn) begin
                  state <= FETCH;   // resume at current pc
               end
            end
            FETCH: begin
               if (RVld) begin
                  state <= DECODE;
                  pc    <= pc + `XLEN'(1);
               end
            end
            DECODE: begin
               if (!decodeNow || stopNow) begin
                  state <= HALTED;
               end
               else if (needMem) begin
                  state <= MEM;
                  memWr <= op.isStore;
               end
               else begin
                  state <= FETCH;
               end
            end
            default: begin
               if (RVld) begin
                  state <= FETCH;
               end
            end
         endcase
      end
   end

   // address, data and target register held through MEM
   always_ff @(posedge clk) begin
      if (decodeNow && needMem) begin
         memAddr <= aluResult;
         memData <= storeData;
         ldRd    <= op.rd;
      end
   end

   assign RRdy      = (state == FETCH) || (state == MEM);
   assign RAddr     = (state == MEM) ? memAddr : pc;
   assign RWEn      = (state == MEM) && memWr;
   assign RWData    = RWEn ? memData : '0;
   assign Halt      = (state == HALTED);
   assign fetchDone = (state == FETCH) && RVld;

   // ALU result at end of DECODE, load data on the MEM answer
   assign wEn   = (decodeNow && op.writesRd && !op.isLoad && !stopNow) ||
                  (memDone && !memWr);
   assign wAddr = (state == MEM) ? ldRd : op.rd;
   assign wData = (state == MEM) ? RData : aluResult;

endmodule

// ==== hdl/lanzones.sv ====
`timescale 1ns/1ps

module lanzones import lanzones_pkg::*; (
   input  logic  clk,
   input  logic  rstn,
   input  logic  RVld,
   input  word_t RData,
   input  logic  LEn,
   output logic  RRdy,
   output word_t RAddr,
   output logic  RWEn,
   output word_t RWData,
   output logic  Halt
);

   logic    fetchDone;
   word_t   rs1Data;
   word_t   rs2Data;
   word_t   aluResult;
   word_t   storeData;
   logic    wEn;
   regIdx_t wAddr;
   word_t   wData;

   decodeIf decBus ();

   instDecoder u_decoder (
      .clk       (clk),
      .rstn      (rstn),
      .fetchDone (fetchDone),
      .RData     (RData),
      .dec       (decBus.dec)
   );

   execUnit u_exec (
      .op        (decBus.user),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .aluResult (aluResult),
      .storeData (storeData)
   );

   regFile u_regs (
      .clk     (clk),
      .rstn    (rstn),
      .rs1     (decBus.rs1),
      .rs2     (decBus.rs2),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data),
      .wEn     (wEn),
      .wAddr   (wAddr),
      .wData   (wData)
   );

   coreSequencer u_seq (
      .clk       (clk),
      .rstn      (rstn),
      .LEn       (LEn),
      .RVld      (RVld),
      .RData     (RData),
      .op        (decBus.user),
      .aluResult (aluResult),
      .storeData (storeData),
      .RRdy      (RRdy),
      .RAddr     (RAddr),
      .RWEn      (RWEn),
      .RWData    (RWData),
      .Halt      (Halt),
      .fetchDone (fetchDone),
      .wEn       (wEn),
      .wAddr     (wAddr),
      .wData     (wData)
   );

endmodule

// ==== verification/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

endmodule

// ==== verification/lanzones_assert.sv ====
`timescale 1ns/1ps

module lanzones_assert import lanzones_pkg::*; (
   input logic  clk,
   input logic  rstn,
   input logic  LEn,
   input logic  RVld,
   input logic  RRdy,
   input word_t RAddr,
   input logic  RWEn,
   input word_t RWData,
   input logic  Halt
);

   int failCount = 0;   // polled by tb_lanzones

   task automatic flagFailure(input string what);
      $error("%s", what);
      failCount++;
   endtask

   // reset leaves the core halted with no request
   resetIdle: assert property (@(posedge clk) !rstn |=> Halt && !RRdy && !RWEn)
      else flagFailure("core not halted and idle after reset");

   haltIdle: assert property (@(posedge clk) disable iff (!rstn) Halt |-> !RRdy && !RWEn)
      else flagFailure("bus request while the core is halted");

   // only LEn restarts the core
   stayHalted: assert property (@(posedge clk) disable iff (!rstn) Halt && !LEn |=> Halt)
      else flagFailure("core left Halt without LEn");

   writeNeedsReq: assert property (@(posedge clk) disable iff (!rstn) RWEn |-> RRdy)
      else flagFailure("RWEn high without RRdy");

   // request held until the memory answers
   holdRequest: assert property (@(posedge clk) disable iff (!rstn)
      RRdy && !RVld |=> $stable(RAddr) && $stable(RWEn) && $stable(RWData))
      else flagFailure("bus request changed while waiting for RVld");

endmodule

bind lanzones lanzones_assert u_assert (.*);

// ==== verification/tb_lanzones.sv ====
`timescale 1ns/1ps

module tb_lanzones;

   logic        clk;
   logic        rstn;
   logic        RVld;
   logic [31:0] RData;
   logic        LEn;
   logic        RRdy;
   logic [31:0] RAddr;
   logic        RWEn;
   logic [31:0] RWData;
   logic        Halt;

   logic [31:0] mem [0:255];       // program low, stores from 100, data at 200
   logic [31:0] expWord [0:255];
   bit          expValid [0:255];
   logic [31:0] refReg [0:31];     // register values by the ISA rules
   int          pcFill;
   int          slot;
   int          firstStores;
   int          expStores;
   int          gotStores;
   logic [31:0] rng;

   tbClock u_clk (.clk(clk));

   lanzones u_dut (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s ^= s << 13;
      s ^= s >> 17;
      s ^= s << 5;
      return s;
   endfunction

   function automatic logic [31:0] refAlu(input logic [2:0] f3, input bit alt,
                                          input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return {31'b0, $signed(a) < $signed(b)};
         3'd3: return {31'b0, a < b};
         3'd4: return a ^ b;
         3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   task automatic abortRun(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic put(input logic [31:0] w, input int rd, input logic [31:0] val);
      mem[pcFill] = w;
      pcFill++;
      if (rd != 0) begin
         refReg[rd] = val;   // x0 stays zero
      end
   endtask

   // OP-IMM when useImm, else OP with src as rs2
   task automatic alu(input bit useImm, input int f3, input bit alt, input int rd,
                      input int rs1, input int src);
      logic [31:0] b;
      logic [31:0] w;
      if (useImm) begin
         b = src;
         alt = (f3 == 5) && b[10];   // SRAI
         w = {b[11:0], 5'(rs1), 3'(f3), 5'(rd), 7'h13};
      end
      else begin
         b = refReg[src];
         w = {1'b0, alt, 5'b0, 5'(src), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
      end
      put(w, rd, refAlu(3'(f3), alt, refReg[rs1], b));
   endtask

   // SW rs2 to the next result slot with base x0
   task automatic store(input int rs2);
      logic [11:0] imm;
      imm = 12'(slot);
      put({imm[11:5], 5'(rs2), 5'd0, 3'b010, imm[4:0], 7'h23}, 0, '0);
      expWord[slot] = refReg[rs2];
      expValid[slot] = 1'b1;
      expStores++;
      slot++;
   endtask

   task automatic startCore();
      @(posedge clk);
      #1 LEn = 1'b1;
      @(posedge clk);
      #1 LEn = 1'b0;
   endtask

   task automatic waitHalt(input string run);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!Halt && n < 3000);
      assert (Halt) else abortRun({"timeout, the core did not halt in the ", run});
   endtask

   // memory answers each request after 0 to 3 idle cycles
   always begin
      @(posedge clk);
      if (rstn && RRdy) begin
         rng = xorshift(rng);
         repeat (rng % 4) @(posedge clk);
         #1;
         RVld  = 1'b1;
         RData = mem[RAddr[7:0]];
         if (RWEn) begin
            assert (RAddr < 256 && expValid[RAddr[7:0]])
               else abortRun($sformatf("unexpected store to word address %0d", RAddr));
            assert (RWData == expWord[RAddr[7:0]])
               else abortRun($sformatf("Error at time %0t: RWData expected %h, got %h",
                                       $time, expWord[RAddr[7:0]], RWData));
            mem[RAddr[7:0]] = RWData;
            expValid[RAddr[7:0]] = 1'b0;
            gotStores++;
         end
         @(posedge clk);
         #1 RVld = 1'b0;
      end
   end

   always @(posedge clk) begin
      assert (u_dut.u_assert.failCount == 0)
         else abortRun("a bus or reset property of the core failed");
   end

   initial begin
      rstn = 1'b0;
      LEn = 1'b0;
      RVld = 1'b0;
      RData = '0;
      rng = 32'd65;
      pcFill = 0;
      slot = 100;
      expStores = 0;
      gotStores = 0;
      for (int i = 0; i < 256; i++) begin
         mem[i] = 32'(i) * 32'h9E37_79B1 + 32'h0BAD_F00D;
         expValid[i] = 1'b0;
      end
      for (int i = 0; i < 32; i++) begin
         refReg[i] = '0;
      end
      put({20'h80001, 5'd1, 7'h37}, 1, {20'h80001, 12'h000});
      alu(1, 0, 0, 1, 1, -5);   // x1 negative
      put({20'h12345, 5'd2, 7'h37}, 2, {20'h12345, 12'h000});
      alu(1, 0, 0, 2, 2, 32'h678);
      // immediate group with a shift amount for the shifts
      for (int f = 0; f < 8; f++) begin
         alu(1, f, 0, 3, 1, (f % 4 == 1) ? 7 : -100);
         store(3);
         alu(1, f, 0, 3, 2, (f % 4 == 1) ? 4 : 90);
         store(3);
      end
      alu(1, 5, 0, 3, 1, 32'h407);
      store(3);
      for (int f = 0; f < 10; f++) begin
         alu(0, (f == 9) ? 5 : f % 8, f >= 8, 4, 1, 2);   // SUB and SRA last
         store(4);
      end
      alu(1, 0, 0, 9, 0, 198);
      put({12'd2, 5'd9, 3'b010, 5'd7, 7'h03}, 7, mem[8'(refReg[9] + 2)]);
      alu(0, 0, 0, 8, 7, 2);
      store(8);
      alu(1, 0, 0, 0, 1, 5);    // dropped write to x0
      store(0);
      put(32'h0000_007F, 0, '0);
      firstStores = expStores;
      alu(1, 0, 0, 10, 0, -42);
      store(10);
      put({7'h01, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33}, 0, '0);   // MUL is not decoded

      repeat (3) @(posedge clk);
      #1 rstn = 1'b1;
      startCore();
      waitHalt("first run");
      repeat (6) @(posedge clk);
      assert (gotStores == firstStores)
         else abortRun("the first run did not store every expected word");
      startCore();
      waitHalt("second run");
      repeat (6) @(posedge clk);
      #1;
      if (gotStores != expStores)
         abortRun("the second run did not store every expected word");
      else if (u_dut.u_assert.failCount != 0)
         abortRun("a bus or reset property of the core failed");
      else
         $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== lanzones.f ====
+incdir+common
common/lanzones_pkg.sv
common/decodeIf.sv
core/instDecoder.sv
core/execUnit.sv
core/regFile.sv
core/coreSequencer.sv
hdl/lanzones.sv
verification/tbClock.sv
verification/lanzones_assert.sv
verification/tb_lanzones.sv

// ==== Bender.yml ====
package:
  name: lanzones

sources:
  - include_dirs:
      - common
    files:
      - common/lanzones_pkg.sv
      - common/decodeIf.sv
      - core/instDecoder.sv
      - core/execUnit.sv
      - core/regFile.sv
      - core/coreSequencer.sv
      - hdl/lanzones.sv
  - target: test
    files:
      - verification/tbClock.sv
      - verification/lanzones_assert.sv
      - verification/tb_lanzones.sv
